/* reb_pkg.sv */
// Shared definitions for the reorder-buffer core
// Buffer sizes and tag and sequence widths
// Opcode encodings used by the allocator decode
// Instruction word union with its op and prefix forms
// Entry, allocation, execute and retire structs

package reb_pkg;

	// ======================================================================
	// Sizes
	// ======================================================================

	// Number of reorder-buffer entries
	localparam int REB_ENTRIES = 6;

	// Entry index width
	localparam int TAG_W = 3;

	// The all-ones index marks the absence of an entry
	localparam logic [TAG_W-1:0] TAG_NONE = {TAG_W{1'b1}};

	// Sequence numbers wrap, so age is always taken relative to the oldest one
	localparam int SEQ_W = 6;

	// ======================================================================
	// Opcodes
	// ======================================================================

	localparam logic [6:0] OP_ALU    = 7'h0C;
	localparam logic [6:0] OP_LOAD   = 7'h40;
	localparam logic [6:0] OP_STORE  = 7'h50;
	localparam logic [6:0] OP_BRANCH = 7'h20;
	// Constant prefix that extends the immediate of the following instruction
	localparam logic [6:0] OP_EXIM   = 7'h0A;

	// ======================================================================
	// Instruction word
	// ======================================================================

	// Regular operation with three register fields and a short immediate
	typedef struct packed {
		logic [6:0] opcode;
		logic [5:0] rd;
		logic [5:0] ra;
		logic [5:0] rb;
		logic [6:0] imm;
	} op_form_s;

	// Prefix form carrying the upper constant bits
	typedef struct packed {
		logic [6:0]  opcode;
		logic [24:0] cval;
	} prefix_form_s;

	// The opcode sits in the top seven bits in both forms
	typedef union packed {
		op_form_s     op;
		prefix_form_s pfx;
	} instr_u;

	// ======================================================================
	// Entry and port records
	// ======================================================================

	// Contents of one reorder-buffer entry
	typedef struct packed {
		logic             v;
		logic             decoded;
		logic             out;
		logic             executed;
		logic             mem;
		logic             flowchg;
		logic             prefix;
		logic             taken;
		logic [SEQ_W-1:0] seq;
		instr_u           ir;
	} entry_s;

	// Write from the allocator into one entry
	typedef struct packed {
		logic             wr;
		logic [SEQ_W-1:0] seq;
		logic             mem;
		logic             flowchg;
		logic             prefix;
		instr_u           ir;
	} alloc_s;

	// Execute port toward the outside execution units
	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		logic [SEQ_W-1:0] seq;
		instr_u           ir;
	} exec_s;

	// Retire record in program order
	typedef struct packed {
		logic             valid;
		logic [SEQ_W-1:0] seq;
		instr_u           ir;
		logic [24:0]      pconst;
		logic             taken;
	} retire_s;

endpackage

/* reb_alloc.sv */
// Allocator for the reorder buffer
// Finds the lowest free entry and writes the issued word into it
// Decodes the opcode into the memory, flow-change and prefix flags
// Keeps the sequence counter and rewinds it on a flush

`timescale 1ns/1ps

module reb_alloc (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       issue,
	input  reb_pkg::instr_u                            issue_word,
	input  reb_pkg::entry_s [reb_pkg::REB_ENTRIES-1:0] entries,
	input  logic                                       flush,
	input  logic [reb_pkg::SEQ_W-1:0]                  flush_seq,
	output reb_pkg::alloc_s [reb_pkg::REB_ENTRIES-1:0] wr,
	output logic                                       full
);

	logic [reb_pkg::REB_ENTRIES-1:0] valid;
	logic [reb_pkg::REB_ENTRIES-1:0] free_oh;
	logic                            accept;
	logic                            mem;
	logic                            flowchg;
	logic                            prefix;
	logic [reb_pkg::SEQ_W-1:0]       next_seq;

	always_comb begin
		for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
			valid[k] = entries[k].v;
		end
	end

	// The buffer is full when every entry holds an instruction
	assign full = &valid;

	// An issue during a flush belongs to the discarded path and is dropped
	assign accept = issue && !full && !flush;

	// Find-first-zero on the valid bits, scanning down so the lowest index wins
	always_comb begin
		free_oh = '0;
		for (int k = reb_pkg::REB_ENTRIES - 1; k >= 0; k--) begin
			if (!valid[k]) begin
				free_oh    = '0;
				free_oh[k] = 1'b1;
			end
		end
	end

	// Opcode decode into the entry flags
	always_comb begin
		mem     = 1'b0;
		flowchg = 1'b0;
		prefix  = 1'b0;
		case (issue_word.op.opcode)
			reb_pkg::OP_LOAD, reb_pkg::OP_STORE: mem = 1'b1;
			reb_pkg::OP_BRANCH:                  flowchg = 1'b1;
			reb_pkg::OP_EXIM:                    prefix = 1'b1;
			// Plain operations raise no flag
			reb_pkg::OP_ALU:                     mem = 1'b0;
			default:                             mem = 1'b0;
		endcase
	end

	// Every entry sees the same payload, only the chosen one gets the strobe
	always_comb begin
		for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
			wr[k].wr      = accept && free_oh[k];
			wr[k].seq     = next_seq;
			wr[k].mem     = mem;
			wr[k].flowchg = flowchg;
			wr[k].prefix  = prefix;
			wr[k].ir      = issue_word;
		end
	end

	// After a taken flow change the numbering restarts just past the branch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			next_seq <= '0;
		end else if (flush) begin
			next_seq <= flush_seq + 1'b1;
		end else if (accept) begin
			next_seq <= next_seq + 1'b1;
		end
	end

endmodule

/* reb_entry.sv */
// One reorder-buffer entry
// State bits valid, decoded, out, executed and the resolved branch direction
// Stored instruction word, sequence number and decode flags
// Clear on retire and clear on flush

`timescale 1ns/1ps

module reb_entry (
	input  logic            clk,
	input  logic            rst_n,
	input  reb_pkg::alloc_s wr,
	input  logic            mark_out,
	input  logic            done,
	input  logic            done_hit,
	input  logic            done_taken,
	input  logic            clear,
	input  logic            flush,
	output reb_pkg::entry_s ent
);

	// Control state
	logic v;
	logic decoded;
	logic out;
	logic executed;
	logic taken;

	// Payload captured at allocation
	logic [reb_pkg::SEQ_W-1:0] seq;
	logic                      mem;
	logic                      flowchg;
	logic                      prefix;
	reb_pkg::instr_u           ir;

	// ======================================================================
	// State bits
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v        <= 1'b0;
			decoded  <= 1'b0;
			out      <= 1'b0;
			executed <= 1'b0;
			taken    <= 1'b0;
		end else if (wr.wr) begin
			v        <= 1'b1;
			decoded  <= 1'b1;
			out      <= 1'b0;
			// A prefix never goes to execute so it is complete on arrival
			executed <= wr.prefix;
			taken    <= 1'b0;
		end else if (clear || flush) begin
			// Flush removes every younger entry and clear removes the retiring one
			v        <= 1'b0;
			decoded  <= 1'b0;
			out      <= 1'b0;
			executed <= 1'b0;
			taken    <= 1'b0;
		end else begin
			if (mark_out) begin
				out <= 1'b1;
			end
			// Completion only counts for an instruction that was actually sent out
			if (done && done_hit && v && out) begin
				executed <= 1'b1;
				taken    <= done_taken;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr.wr) begin
			seq     <= wr.seq;
			mem     <= wr.mem;
			flowchg <= wr.flowchg;
			prefix  <= wr.prefix;
			ir      <= wr.ir;
		end
	end

	always_comb begin
		ent.v        = v;
		ent.decoded  = decoded;
		ent.out      = out;
		ent.executed = executed;
		ent.mem      = mem;
		ent.flowchg  = flowchg;
		ent.prefix   = prefix;
		ent.taken    = taken;
		ent.seq      = seq;
		ent.ir       = ir;
	end

endmodule

/* reb_schedule.sv */
// Execute scheduler
// Age of each entry relative to the oldest sequence number
// Ordering rules for memory operations and flow changes
// Oldest-eligible pick, one-hot mark to the entries and the registered port

`timescale 1ns/1ps

module reb_schedule (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  reb_pkg::entry_s [reb_pkg::REB_ENTRIES-1:0] entries,
	input  logic [reb_pkg::SEQ_W-1:0]                  oldest_seq,
	output logic [reb_pkg::REB_ENTRIES-1:0]            mark_out,
	output reb_pkg::exec_s                             exec
);

	logic [reb_pkg::SEQ_W-1:0]       age [reb_pkg::REB_ENTRIES];
	logic [reb_pkg::REB_ENTRIES-1:0] older_mem;
	logic [reb_pkg::REB_ENTRIES-1:0] older_fc;
	logic [reb_pkg::REB_ENTRIES-1:0] eligible;
	logic [reb_pkg::TAG_W-1:0]       pick;
	logic [reb_pkg::SEQ_W-1:0]       pick_age;
	reb_pkg::entry_s                 pick_ent;

	logic                      exec_valid;
	logic [reb_pkg::TAG_W-1:0] exec_tag;
	logic [reb_pkg::SEQ_W-1:0] exec_seq;
	reb_pkg::instr_u           exec_ir;

	// ======================================================================
	// Ordering conditions
	// ======================================================================

	// Modulo subtraction keeps the order right across a sequence wrap
	always_comb begin
		for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
			age[k] = entries[k].seq - oldest_seq;
		end
	end

	// For each entry look at every strictly older valid entry
	always_comb begin
		for (int i = 0; i < reb_pkg::REB_ENTRIES; i++) begin
			older_mem[i] = 1'b0;
			older_fc[i]  = 1'b0;
			for (int j = 0; j < reb_pkg::REB_ENTRIES; j++) begin
				if (entries[j].v && age[j] < age[i]) begin
					if (entries[j].mem && !entries[j].executed) begin
						older_mem[i] = 1'b1;
					end
					// A resolved taken branch also holds back everything behind it
					// until its flush removes the wrong path
					if (entries[j].flowchg && (!entries[j].executed || entries[j].taken)) begin
						older_fc[i] = 1'b1;
					end
				end
			end
		end
	end

	// Ready once decoded, since operand tracking is not modelled
	always_comb begin
		for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
			eligible[k] = entries[k].v && entries[k].decoded && !entries[k].out &&
				!entries[k].executed && !entries[k].prefix &&
				!(entries[k].mem && older_mem[k]) && !older_fc[k];
		end
	end

	// ======================================================================
	// Oldest-eligible pick
	// ======================================================================

	always_comb begin
		pick     = reb_pkg::TAG_NONE;
		pick_age = '1;
		for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
			if (eligible[k] && (pick == reb_pkg::TAG_NONE || age[k] < pick_age)) begin
				pick     = k[reb_pkg::TAG_W-1:0];
				pick_age = age[k];
			end
		end
	end

	// The mark sets out in the chosen entry at the same edge that loads the port
	always_comb begin
		mark_out = '0;
		pick_ent = '0;
		for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
			if (pick == k[reb_pkg::TAG_W-1:0]) begin
				mark_out[k] = 1'b1;
				pick_ent    = entries[k];
			end
		end
	end

	// ======================================================================
	// Execute port
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exec_valid <= 1'b0;
		end else begin
			exec_valid <= (pick != reb_pkg::TAG_NONE);
		end
	end

	always_ff @(posedge clk) begin
		if (pick != reb_pkg::TAG_NONE) begin
			exec_tag <= pick;
			exec_seq <= pick_ent.seq;
			exec_ir  <= pick_ent.ir;
		end
	end

	always_comb begin
		exec.valid = exec_valid;
		exec.tag   = exec_tag;
		exec.seq   = exec_seq;
		exec.ir    = exec_ir;
	end

endmodule

/* reb_retire.sv */
// In-order retire for the reorder buffer
// Tracks the oldest sequence number and finds the matching entry
// Merges a prefix constant into the record of the next instruction
// Raises the flush when a taken flow change retires

`timescale 1ns/1ps

module reb_retire (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  reb_pkg::entry_s [reb_pkg::REB_ENTRIES-1:0] entries,
	output logic [reb_pkg::REB_ENTRIES-1:0]            clear,
	output logic                                       flush,
	output logic [reb_pkg::SEQ_W-1:0]                  flush_seq,
	output logic [reb_pkg::SEQ_W-1:0]                  oldest_seq,
	output reb_pkg::retire_s                           retire
);

	logic [reb_pkg::REB_ENTRIES-1:0] head_hit;
	reb_pkg::entry_s                 head_ent;
	logic                            go;
	logic [24:0]                     pconst_q;

	logic                      ret_valid;
	logic [reb_pkg::SEQ_W-1:0] ret_seq;
	reb_pkg::instr_u           ret_ir;
	logic [24:0]               ret_pconst;
	logic                      ret_taken;

	// Sequence numbers are unique within the window so at most one entry matches
	always_comb begin
		head_hit = '0;
		head_ent = '0;
		for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
			if (entries[k].v && entries[k].seq == oldest_seq) begin
				head_hit[k] = 1'b1;
				head_ent    = entries[k];
			end
		end
	end

	// The head leaves as soon as it has executed
	assign go        = |head_hit && head_ent.executed;
	assign clear     = head_hit & {reb_pkg::REB_ENTRIES{go}};
	assign flush     = go && head_ent.flowchg && head_ent.taken;
	assign flush_seq = head_ent.seq;

	// ======================================================================
	// Retire state
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			oldest_seq <= '0;
			ret_valid  <= 1'b0;
			pconst_q   <= '0;
		end else begin
			// Prefixes retire silently
			ret_valid <= go && !head_ent.prefix;
			if (go) begin
				oldest_seq <= oldest_seq + 1'b1;
				// The constant lives only until the next instruction takes it
				if (head_ent.prefix) begin
					pconst_q <= head_ent.ir.pfx.cval;
				end else begin
					pconst_q <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (go && !head_ent.prefix) begin
			ret_seq    <= head_ent.seq;
			ret_ir     <= head_ent.ir;
			ret_pconst <= pconst_q;
			ret_taken  <= head_ent.taken;
		end
	end

	always_comb begin
		retire.valid  = ret_valid;
		retire.seq    = ret_seq;
		retire.ir     = ret_ir;
		retire.pconst = ret_pconst;
		retire.taken  = ret_taken;
	end

endmodule

/* reb_top.sv */
// Top level of the instruction-tracking core
// Allocator, six reorder-buffer entries, execute scheduler and retirer
// Decode of the completion tag into per-entry hits

`timescale 1ns/1ps

module reb_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      issue,
	input  reb_pkg::instr_u           issue_word,
	input  logic                      done,
	input  logic [reb_pkg::TAG_W-1:0] done_tag,
	input  logic                      done_taken,
	output logic                      full,
	output reb_pkg::exec_s            exec,
	output reb_pkg::retire_s          retire
);

	reb_pkg::entry_s [reb_pkg::REB_ENTRIES-1:0] entries;
	reb_pkg::alloc_s [reb_pkg::REB_ENTRIES-1:0] wr;
	logic [reb_pkg::REB_ENTRIES-1:0]            mark_out;
	logic [reb_pkg::REB_ENTRIES-1:0]            clear;
	logic [reb_pkg::REB_ENTRIES-1:0]            done_sel;
	logic                                       flush;
	logic [reb_pkg::SEQ_W-1:0]                  flush_seq;
	logic [reb_pkg::SEQ_W-1:0]                  oldest_seq;

	reb_alloc u_alloc (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.issue_word (issue_word),
		.entries    (entries),
		.flush      (flush),
		.flush_seq  (flush_seq),
		.wr         (wr),
		.full       (full)
	);

	// Completion tag compared against each entry index
	always_comb begin
		for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
			done_sel[k] = (done_tag == k[reb_pkg::TAG_W-1:0]);
		end
	end

	for (genvar i = 0; i < reb_pkg::REB_ENTRIES; i++) begin : g_entry
		reb_entry u_entry (
			.clk        (clk),
			.rst_n      (rst_n),
			.wr         (wr[i]),
			.mark_out   (mark_out[i]),
			.done       (done),
			.done_hit   (done_sel[i]),
			.done_taken (done_taken),
			.clear      (clear[i]),
			.flush      (flush),
			.ent        (entries[i])
		);
	end

	reb_schedule u_schedule (
		.clk        (clk),
		.rst_n      (rst_n),
		.entries    (entries),
		.oldest_seq (oldest_seq),
		.mark_out   (mark_out),
		.exec       (exec)
	);

	reb_retire u_retire (
		.clk        (clk),
		.rst_n      (rst_n),
		.entries    (entries),
		.clear      (clear),
		.flush      (flush),
		.flush_seq  (flush_seq),
		.oldest_seq (oldest_seq),
		.retire     (retire)
	);

endmodule

/* tb_reb.sv */
// Testbench for the reorder-buffer core
// Stimulus table of instruction words, branch directions and completion delays
// Program-order reference model with entry slots for the execute and retire ports
// Completion queue that answers each execute with a delayed done
// Compare tasks for execute records, retire records and single levels

`timescale 1ns/1ps

module tb_reb;

	typedef struct {
		reb_pkg::instr_u word;
		logic            taken;
		int              delay;
	} stim_s;

	// One issued instruction as the reference model sees it
	typedef struct {
		reb_pkg::instr_u           word;
		logic [reb_pkg::SEQ_W-1:0] seq;
		logic [reb_pkg::TAG_W-1:0] tag;
		logic                      is_mem;
		logic                      is_br;
		logic                      is_pfx;
		logic                      taken;
		logic                      out;
		int                        delay;
		int                        iss_cyc;
		int                        done_cyc;
	} model_s;

	typedef struct {
		logic [reb_pkg::TAG_W-1:0] tag;
		logic [reb_pkg::SEQ_W-1:0] seq;
		logic                      taken;
		int                        due;
	} done_s;

	logic                      clk;
	logic                      rst_n;
	logic                      issue;
	reb_pkg::instr_u           issue_word;
	logic                      done;
	logic [reb_pkg::TAG_W-1:0] done_tag;
	logic                      done_taken;
	logic                      full;
	reb_pkg::exec_s            exec;
	reb_pkg::retire_s          retire;

	stim_s                           stim_q [$];
	model_s                          inflight [$];
	done_s                           pending [$];
	int                              cyc;
	int                              cycle_limit;
	int                              next_stim;
	logic [reb_pkg::SEQ_W-1:0]       model_seq;
	logic [reb_pkg::REB_ENTRIES-1:0] slot_busy;
	logic [24:0]                     model_pc;
	logic                            hold_issue;
	logic                            saw_full;

	reb_top u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.issue_word (issue_word),
		.done       (done),
		.done_tag   (done_tag),
		.done_taken (done_taken),
		.full       (full),
		.exec       (exec),
		.retire     (retire)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ======================================================================
	// Reporting and compare tasks
	// ======================================================================

	task automatic stop_run(string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_level(string what, logic got, logic exp);
		if (got !== exp) begin
			stop_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_exec(reb_pkg::exec_s got, reb_pkg::exec_s exp);
		if (got !== exp) begin
			stop_run({$sformatf("MISMATCH at %0t: exec tag %0d seq %0d word %h,",
				$time, got.tag, got.seq, got.ir),
				$sformatf(" expected tag %0d seq %0d word %h", exp.tag, exp.seq, exp.ir)});
		end
	endtask

	task automatic check_retire(reb_pkg::retire_s got, reb_pkg::retire_s exp);
		if (got !== exp) begin
			stop_run({$sformatf("MISMATCH at %0t: retire seq %0d word %h pconst %h taken %b,",
				$time, got.seq, got.ir, got.pconst, got.taken),
				$sformatf(" expected seq %0d word %h pconst %h taken %b",
				exp.seq, exp.ir, exp.pconst, exp.taken)});
		end
	endtask

	// ======================================================================
	// Stimulus table
	// ======================================================================

	function automatic reb_pkg::instr_u op_word(logic [6:0] opcode, logic [5:0] rd,
		logic [5:0] ra, logic [5:0] rb, logic [6:0] imm);
		reb_pkg::instr_u w;
		w.op.opcode = opcode;
		w.op.rd     = rd;
		w.op.ra     = ra;
		w.op.rb     = rb;
		w.op.imm    = imm;
		return w;
	endfunction

	function automatic reb_pkg::instr_u pfx_word(logic [24:0] cval);
		reb_pkg::instr_u w;
		w.pfx.opcode = reb_pkg::OP_EXIM;
		w.pfx.cval   = cval;
		return w;
	endfunction

	task automatic put_stim(reb_pkg::instr_u word, logic taken, int delay);
		stim_s s;
		s.word  = word;
		s.taken = taken;
		s.delay = delay;
		stim_q.push_back(s);
	endtask

	task automatic build_table();
		// A slow load at the head lets the next five fill the buffer
		put_stim(op_word(reb_pkg::OP_LOAD, 6'd1, 6'd2, 6'd0, 7'd4), 1'b0, 12);
		put_stim(op_word(reb_pkg::OP_ALU, 6'd3, 6'd1, 6'd2, 7'd1), 1'b0, 1);
		put_stim(op_word(reb_pkg::OP_STORE, 6'd0, 6'd3, 6'd4, 7'd8), 1'b0, 1);
		put_stim(op_word(reb_pkg::OP_ALU, 6'd5, 6'd5, 6'd6, 7'd2), 1'b0, 0);
		put_stim(op_word(reb_pkg::OP_ALU, 6'd7, 6'd3, 6'd5, 7'd3), 1'b0, 2);
		put_stim(op_word(reb_pkg::OP_LOAD, 6'd8, 6'd9, 6'd0, 7'd12), 1'b0, 1);
		put_stim(pfx_word(25'h0ABCDE), 1'b0, 0);
		put_stim(op_word(reb_pkg::OP_ALU, 6'd10, 6'd8, 6'd1, 7'd6), 1'b0, 2);
		put_stim(op_word(reb_pkg::OP_BRANCH, 6'd0, 6'd10, 6'd0, 7'd16), 1'b0, 5);
		put_stim(op_word(reb_pkg::OP_ALU, 6'd11, 6'd10, 6'd7, 7'd0), 1'b0, 1);
		put_stim(op_word(reb_pkg::OP_STORE, 6'd0, 6'd11, 6'd8, 7'd20), 1'b0, 2);
		// Prefix ahead of a taken branch, the branch carries its constant
		put_stim(pfx_word(25'h1F00F1), 1'b0, 0);
		put_stim(op_word(reb_pkg::OP_BRANCH, 6'd0, 6'd11, 6'd0, 7'd40), 1'b1, 8);
		// Younger work that is normally on the wrong path
		put_stim(op_word(reb_pkg::OP_ALU, 6'd12, 6'd12, 6'd12, 7'd1), 1'b0, 1);
		put_stim(op_word(reb_pkg::OP_STORE, 6'd0, 6'd12, 6'd1, 7'd24), 1'b0, 1);
		put_stim(pfx_word(25'h000123), 1'b0, 0);
		put_stim(op_word(reb_pkg::OP_ALU, 6'd13, 6'd2, 6'd3, 7'd9), 1'b0, 1);
		put_stim(op_word(reb_pkg::OP_LOAD, 6'd14, 6'd13, 6'd0, 7'd28), 1'b0, 3);
		put_stim(op_word(reb_pkg::OP_ALU, 6'd15, 6'd14, 6'd13, 7'd5), 1'b0, 0);
		put_stim(op_word(reb_pkg::OP_BRANCH, 6'd0, 6'd15, 6'd0, 7'd44), 1'b1, 2);
		put_stim(op_word(reb_pkg::OP_ALU, 6'd16, 6'd4, 6'd5, 7'd7), 1'b0, 1);
		// Two prefixes in a row, the later one wins
		put_stim(pfx_word(25'h155555), 1'b0, 0);
		put_stim(pfx_word(25'h0AAAAA), 1'b0, 0);
		put_stim(op_word(reb_pkg::OP_STORE, 6'd0, 6'd16, 6'd2, 7'd32), 1'b0, 2);
		put_stim(op_word(reb_pkg::OP_BRANCH, 6'd0, 6'd16, 6'd0, 7'd48), 1'b0, 1);
		put_stim(op_word(reb_pkg::OP_ALU, 6'd17, 6'd16, 6'd15, 7'd11), 1'b0, 1);
	endtask

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic bit work_left();
		bit busy;
		busy = (next_stim < stim_q.size()) || (pending.size() > 0);
		foreach (inflight[i]) begin
			if (!inflight[i].is_pfx) begin
				busy = 1'b1;
			end
		end
		return busy;
	endfunction

	// Each execute must be an in-flight instruction that obeys the ordering rules
	task automatic observe_exec();
		reb_pkg::exec_s exp;
		done_s          d;
		int             idx;
		if (!exec.valid) begin
			return;
		end
		idx = -1;
		foreach (inflight[i]) begin
			if (inflight[i].seq == exec.seq) begin
				idx = i;
			end
		end
		if (idx < 0) begin
			stop_run($sformatf("Execute of seq %0d which is not in flight", exec.seq));
		end
		if (inflight[idx].is_pfx) begin
			stop_run("A constant prefix was sent to execute");
		end
		if (inflight[idx].out) begin
			stop_run("An instruction was sent to execute twice");
		end
		for (int i = 0; i < idx; i++) begin
			// A done sets executed at the next edge and the pick shows one edge later
			if (inflight[i].is_br && (inflight[i].taken ||
				inflight[i].done_cyc < 0 || inflight[i].done_cyc >= cyc - 1)) begin
				stop_run("Execute behind an unresolved or taken branch");
			end
			if (inflight[idx].is_mem && inflight[i].is_mem &&
				(inflight[i].done_cyc < 0 || inflight[i].done_cyc >= cyc - 1)) begin
				stop_run("Memory operation executed ahead of an older memory operation");
			end
		end
		exp.valid = 1'b1;
		exp.tag   = inflight[idx].tag;
		exp.seq   = inflight[idx].seq;
		exp.ir    = inflight[idx].word;
		check_exec(exec, exp);
		inflight[idx].out = 1'b1;
		d.tag   = inflight[idx].tag;
		d.seq   = inflight[idx].seq;
		d.taken = inflight[idx].taken;
		d.due   = cyc + inflight[idx].delay;
		pending.push_back(d);
	endtask

	// A prefix leaves one edge after it is both written and the oldest entry
	task automatic retire_prefix();
		if (inflight.size() > 0 && inflight[0].is_pfx &&
			inflight[0].iss_cyc <= cyc - 2) begin
			model_pc = inflight[0].word.pfx.cval;
			slot_busy[inflight[0].tag] = 1'b0;
			inflight.delete(0);
		end
	endtask

	// Retire takes the next instruction in program order with the last prefix constant
	task automatic observe_retire();
		reb_pkg::retire_s exp;
		model_s           head;
		if (!retire.valid) begin
			return;
		end
		if (inflight.size() == 0) begin
			stop_run("Retire record with no instruction outstanding");
		end
		head = inflight.pop_front();
		if (head.is_pfx) begin
			stop_run("A constant prefix appeared on the retire port");
		end
		exp.valid  = 1'b1;
		exp.seq    = head.seq;
		exp.ir     = head.word;
		exp.pconst = model_pc;
		exp.taken  = head.is_br && head.taken;
		check_retire(retire, exp);
		model_pc = '0;
		slot_busy[head.tag] = 1'b0;
		// The taken branch discards everything issued after it
		if (head.is_br && head.taken) begin
			inflight.delete();
			slot_busy = '0;
			if (pending.size() != 0) begin
				stop_run("A flushed instruction still had a completion outstanding");
			end
			model_seq  = head.seq + 1'b1;
			hold_issue = 1'b0;
		end
	endtask

	// Every written instruction that has not left yet holds one entry
	task automatic check_full();
		check_level("full", full, inflight.size() == reb_pkg::REB_ENTRIES);
		if (full) begin
			saw_full = 1'b1;
		end
	endtask

	// At most one completion per cycle, oldest overdue first
	task automatic send_done();
		int pick;
		pick = -1;
		foreach (pending[i]) begin
			if (pick < 0 && pending[i].due <= cyc) begin
				pick = i;
			end
		end
		if (pick < 0) begin
			return;
		end
		done       = 1'b1;
		done_tag   = pending[pick].tag;
		done_taken = pending[pick].taken;
		foreach (inflight[i]) begin
			if (inflight[i].seq == pending[pick].seq) begin
				inflight[i].done_cyc = cyc;
			end
		end
		// No issue between a taken branch completing and its flush
		if (pending[pick].taken) begin
			hold_issue = 1'b1;
		end
		pending.delete(pick);
	endtask

	task automatic drive_issue();
		model_s                    m;
		logic [reb_pkg::TAG_W-1:0] tag;
		if (hold_issue || full || next_stim >= stim_q.size()) begin
			return;
		end
		// The new instruction lands in the lowest free entry
		tag = reb_pkg::TAG_NONE;
		for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
			if (!slot_busy[k] && tag == reb_pkg::TAG_NONE) begin
				tag = k[reb_pkg::TAG_W-1:0];
			end
		end
		issue      = 1'b1;
		issue_word = stim_q[next_stim].word;
		m.word     = stim_q[next_stim].word;
		m.seq      = model_seq;
		m.tag      = tag;
		m.is_mem   = (m.word.op.opcode == reb_pkg::OP_LOAD) ||
			(m.word.op.opcode == reb_pkg::OP_STORE);
		m.is_br    = (m.word.op.opcode == reb_pkg::OP_BRANCH);
		m.is_pfx   = (m.word.op.opcode == reb_pkg::OP_EXIM);
		m.taken    = stim_q[next_stim].taken;
		m.out      = 1'b0;
		m.delay    = stim_q[next_stim].delay + int'($urandom_range(2, 0));
		m.iss_cyc  = cyc;
		m.done_cyc = -1;
		inflight.push_back(m);
		slot_busy[tag] = 1'b1;
		model_seq = model_seq + 1'b1;
		next_stim++;
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		void'($urandom(32'h159de641));
		rst_n      = 1'b0;
		issue      = 1'b0;
		issue_word = '0;
		done       = 1'b0;
		done_tag   = '0;
		done_taken = 1'b0;
		next_stim  = 0;
		model_seq  = '0;
		slot_busy  = '0;
		model_pc   = '0;
		hold_issue = 1'b0;
		saw_full   = 1'b0;
		cyc        = 0;
		build_table();
		cycle_limit = 40 * stim_q.size() + 100;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_level("full after reset", full, 1'b0);
		check_level("exec.valid after reset", exec.valid, 1'b0);
		check_level("retire.valid after reset", retire.valid, 1'b0);
		while (work_left()) begin
			@(posedge clk);
			#1;
			cyc++;
			if (cyc > cycle_limit) begin
				stop_run($sformatf("Timeout after %0d cycles with work still outstanding", cyc));
			end
			issue = 1'b0;
			done  = 1'b0;
			observe_exec();
			retire_prefix();
			observe_retire();
			check_full();
			send_done();
			drive_issue();
		end
		issue = 1'b0;
		done  = 1'b0;
		// Drained buffer stays quiet
		repeat (10) begin
			@(posedge clk);
			#1;
			check_level("exec.valid when idle", exec.valid, 1'b0);
			check_level("retire.valid when idle", retire.valid, 1'b0);
			check_level("full when idle", full, 1'b0);
		end
		if (!saw_full) begin
			stop_run("The buffer never filled, so the full level was not exercised");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

/* verilog.f */
reb_pkg.sv
reb_alloc.sv
reb_entry.sv
reb_schedule.sv
reb_retire.sv
reb_top.sv
tb_reb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the reorder-buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f verilog.f --top-module tb_reb -o Vtb_reb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_reb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
